// ==== verilog/blur_pkg.sv ====
package blur_pkg;

  // image geometry
  localparam int PIXEL_W      = 8;
  localparam int STRIP_PIXELS = 16;
  localparam int HALO         = 3;
  localparam int MAX_COLS     = 40;

  // derived widths
  localparam int WIN_PIXELS = STRIP_PIXELS + 2 * HALO;
  localparam int STRIP_W    = PIXEL_W * STRIP_PIXELS;
  localparam int WINDOW_W   = PIXEL_W * WIN_PIXELS;
  localparam int ROW_WORD_W = STRIP_W * MAX_COLS;
  localparam int ADDR_W     = 9;
  localparam int COL_W      = 6;

  typedef logic [PIXEL_W-1:0] pixel_t;

  // pixel i sits in byte i, lowest byte first
  typedef logic [STRIP_W-1:0] strip_t;

  // window pixel j maps to image x = strip * 16 + j - 3
  typedef logic [WINDOW_W-1:0] window_t;

  // strip c occupies bits c*128 upward
  typedef logic [ROW_WORD_W-1:0] row_word_t;

  typedef logic [ADDR_W-1:0] row_addr_t;
  typedef logic [COL_W-1:0]  col_idx_t;

  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_FIRST_COL = 2'd1,
    ST_NEXT_COL  = 2'd2,
    ST_NEXT_ROW  = 2'd3
  } seq_state_e;

endpackage

// ==== verilog/blur_ctrl_if.sv ====
`timescale 1ns/1ps

interface blur_ctrl_if;

  // high for every cycle of the row walk
  logic                row_phase;
  // idle or between strips, clears datapath counters
  logic                col_start;
  blur_pkg::col_idx_t  current_col;
  // single pulse on the last blur memory write of a strip
  logic                strip_rows_done;

  modport seq (
    output row_phase,
    output col_start,
    output current_col,
    input  strip_rows_done
  );

  modport dp (
    input  row_phase,
    input  col_start,
    input  current_col,
    output strip_rows_done
  );

endinterface

// ==== verilog/strip_sequencer.sv ====
`timescale 1ns/1ps

module strip_sequencer #(
  parameter int NUM_COLS = 40,
  parameter int NUM_ROWS = 480
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  blur_ctrl_if.seq            ctrl,
  output logic                done,
  output blur_pkg::row_addr_t img_addr,
  output logic                buffer_we,
  output logic                fill_zero
);

  localparam blur_pkg::row_addr_t ROWS      = blur_pkg::row_addr_t'(NUM_ROWS);
  localparam blur_pkg::row_addr_t FILL_FROM = blur_pkg::row_addr_t'(NUM_ROWS - 2);
  localparam blur_pkg::col_idx_t  LAST_COL  = blur_pkg::col_idx_t'(NUM_COLS - 1);

  blur_pkg::seq_state_e state;
  blur_pkg::seq_state_e state_next;
  logic [1:0]           relay;
  blur_pkg::row_addr_t  row_cnt;
  logic                 priming;
  logic                 in_rows;
  logic                 last_col;

  assign priming  = (state == blur_pkg::ST_FIRST_COL) || (state == blur_pkg::ST_NEXT_COL);
  assign in_rows  = (state == blur_pkg::ST_NEXT_ROW);
  assign last_col = (ctrl.current_col == LAST_COL);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= blur_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      blur_pkg::ST_IDLE: begin
        if (start) begin
          state_next = blur_pkg::ST_FIRST_COL;
        end
      end
      blur_pkg::ST_FIRST_COL, blur_pkg::ST_NEXT_COL: begin
        // two rows must sit in the line buffer first
        if (relay == 2'd2) begin
          state_next = blur_pkg::ST_NEXT_ROW;
        end
      end
      blur_pkg::ST_NEXT_ROW: begin
        if (ctrl.strip_rows_done) begin
          state_next = last_col ? blur_pkg::ST_IDLE : blur_pkg::ST_NEXT_COL;
        end
      end
      default: state_next = blur_pkg::ST_IDLE;
    endcase
  end

  // priming relay counts 0, 1, 2
  always_ff @(posedge clk) begin
    if (!rst_n || !priming) begin
      relay <= 2'd0;
    end else begin
      relay <= relay + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || state == blur_pkg::ST_IDLE) begin
      ctrl.current_col <= '0;
    end else if (in_rows && ctrl.strip_rows_done) begin
      ctrl.current_col <= last_col ? '0 : ctrl.current_col + 1'b1;
    end
  end

  // row count saturates at NUM_ROWS
  always_ff @(posedge clk) begin
    if (!rst_n || !in_rows) begin
      row_cnt <= '0;
    end else if (row_cnt < ROWS) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

  // image address runs two rows ahead of the row walk
  always_ff @(posedge clk) begin
    if (!rst_n || state == blur_pkg::ST_IDLE) begin
      img_addr <= '0;
    end else if (priming) begin
      if (relay != 2'd0) begin
        img_addr <= img_addr + 1'b1;
      end
    end else if (ctrl.strip_rows_done) begin
      img_addr <= '0;
    end else if (img_addr < ROWS) begin
      img_addr <= img_addr + 1'b1;
    end
  end

  assign buffer_we = (priming && relay != 2'd0) || (in_rows && row_cnt < ROWS);

  // bottom border, last two loads are zero rows
  assign fill_zero = in_rows && (row_cnt < ROWS) && (row_cnt >= FILL_FROM);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= in_rows && ctrl.strip_rows_done && last_col;
    end
  end

  assign ctrl.row_phase = in_rows;
  assign ctrl.col_start = (state == blur_pkg::ST_IDLE) || (state == blur_pkg::ST_NEXT_COL);

endmodule

// ==== verilog/blur_mem_addr_gen.sv ====
`timescale 1ns/1ps

module blur_mem_addr_gen #(
  parameter int NUM_ROWS = 480
) (
  input  logic                clk,
  input  logic                rst_n,
  blur_ctrl_if.dp             ctrl,
  output blur_pkg::row_addr_t blur_addr_r,
  output blur_pkg::row_addr_t blur_addr_w,
  output logic                blur_we
);

  localparam blur_pkg::row_addr_t ROWS     = blur_pkg::row_addr_t'(NUM_ROWS);
  localparam blur_pkg::row_addr_t LAST_ROW = blur_pkg::row_addr_t'(NUM_ROWS - 1);

  logic rd_valid;
  logic rd_valid_d;

  // a row is read while the walk is below the image height
  assign rd_valid = ctrl.row_phase && (blur_addr_r < ROWS);

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.col_start) begin
      blur_addr_r <= '0;
    end else if (rd_valid) begin
      blur_addr_r <= blur_addr_r + 1'b1;
    end
  end

  // read to write is two cycles
  // memory return, then kernel and merge registers
  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.col_start) begin
      rd_valid_d <= 1'b0;
      blur_we    <= 1'b0;
    end else begin
      rd_valid_d <= rd_valid;
      blur_we    <= rd_valid_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.col_start) begin
      blur_addr_w <= '0;
    end else if (blur_we) begin
      blur_addr_w <= blur_addr_w + 1'b1;
    end
  end

  // final write of the strip
  assign ctrl.strip_rows_done = blur_we && (blur_addr_w == LAST_ROW);

endmodule

// ==== verilog/gauss3_strip.sv ====
`timescale 1ns/1ps

module gauss3_strip (
  input  logic              clk,
  input  logic              rst_n,
  input  blur_pkg::window_t win_top,
  input  blur_pkg::window_t win_mid,
  input  blur_pkg::window_t win_bot,
  output blur_pkg::strip_t  blur_strip
);

  // horizontal 1 2 1 around window pixel c
  function automatic logic [9:0] tap3(blur_pkg::window_t win, int c);
    logic [9:0] left;
    logic [9:0] centre;
    logic [9:0] right;
    left   = 10'(win[(c - 1) * blur_pkg::PIXEL_W +: blur_pkg::PIXEL_W]);
    centre = 10'(win[c * blur_pkg::PIXEL_W +: blur_pkg::PIXEL_W]);
    right  = 10'(win[(c + 1) * blur_pkg::PIXEL_W +: blur_pkg::PIXEL_W]);
    return left + (centre << 1) + right;
  endfunction

  blur_pkg::strip_t blur_next;

  // only the centre 18 window pixels contribute
  for (genvar i = 0; i < blur_pkg::STRIP_PIXELS; i++) begin : g_pix
    logic [11:0] acc;

    // vertical 1 2 1, max 4080 fits 12 bits
    assign acc = 12'(tap3(win_top, i + blur_pkg::HALO))
               + (12'(tap3(win_mid, i + blur_pkg::HALO)) << 1)
               + 12'(tap3(win_bot, i + blur_pkg::HALO));

    // divide by 16, truncated
    assign blur_next[i * blur_pkg::PIXEL_W +: blur_pkg::PIXEL_W] = blur_pkg::pixel_t'(acc >> 4);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_strip <= '0;
    end else begin
      blur_strip <= blur_next;
    end
  end

endmodule

// ==== verilog/strip_merge.sv ====
`timescale 1ns/1ps

module strip_merge (
  input  logic                clk,
  input  logic                rst_n,
  blur_ctrl_if.dp             ctrl,
  input  blur_pkg::strip_t    blur_strip,
  input  blur_pkg::row_word_t blur_dout,
  output blur_pkg::row_word_t blur_din
);

  blur_pkg::row_word_t merged;

  // lower strips kept, current strip replaced, upper strips zero
  always_comb begin
    for (int c = 0; c < blur_pkg::MAX_COLS; c++) begin
      if (c < int'(ctrl.current_col)) begin
        merged[c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W] =
          blur_dout[c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W];
      end else if (c == int'(ctrl.current_col)) begin
        merged[c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W] = blur_strip;
      end else begin
        merged[c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W] = '0;
      end
    end
  end

  // free running, blur_we picks the valid cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_din <= '0;
    end else begin
      blur_din <= merged;
    end
  end

endmodule

// ==== verilog/gaussian_blur_top.sv ====
`timescale 1ns/1ps

module gaussian_blur_top #(
  parameter int NUM_COLS = 40,
  parameter int NUM_ROWS = 480
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  output logic                done,
  output blur_pkg::row_addr_t img_addr,
  output logic                buffer_we,
  output logic                fill_zero,
  output blur_pkg::col_idx_t  current_col,
  input  blur_pkg::window_t   buffer_data_0,
  input  blur_pkg::window_t   buffer_data_1,
  input  blur_pkg::window_t   buffer_data_2,
  output blur_pkg::row_addr_t blur_addr_r,
  input  blur_pkg::row_word_t blur_dout,
  output blur_pkg::row_addr_t blur_addr_w,
  output logic                blur_we,
  output blur_pkg::row_word_t blur_din
);

  blur_ctrl_if ctrl ();

  blur_pkg::strip_t blur_strip;

  strip_sequencer #(
    .NUM_COLS (NUM_COLS),
    .NUM_ROWS (NUM_ROWS)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .ctrl      (ctrl.seq),
    .done      (done),
    .img_addr  (img_addr),
    .buffer_we (buffer_we),
    .fill_zero (fill_zero)
  );

  blur_mem_addr_gen #(
    .NUM_ROWS (NUM_ROWS)
  ) u_addr (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl.dp),
    .blur_addr_r (blur_addr_r),
    .blur_addr_w (blur_addr_w),
    .blur_we     (blur_we)
  );

  // buffer row 0 is the newest, one below the output row
  gauss3_strip u_kernel (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_top    (buffer_data_0),
    .win_mid    (buffer_data_1),
    .win_bot    (buffer_data_2),
    .blur_strip (blur_strip)
  );

  strip_merge u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl.dp),
    .blur_strip (blur_strip),
    .blur_dout  (blur_dout),
    .blur_din   (blur_din)
  );

  assign current_col = ctrl.current_col;

endmodule

// ==== verification/tb_blur_env.sv ====
`timescale 1ns/1ps

module tb_blur_env #(
  parameter int NUM_COLS = 3,
  parameter int NUM_ROWS = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  blur_pkg::pixel_t    image [NUM_ROWS][NUM_COLS * blur_pkg::STRIP_PIXELS],
  input  blur_pkg::row_addr_t img_addr,
  input  logic                buffer_we,
  input  logic                fill_zero,
  input  blur_pkg::col_idx_t  current_col,
  output blur_pkg::window_t   buffer_data_0,
  output blur_pkg::window_t   buffer_data_1,
  output blur_pkg::window_t   buffer_data_2,
  input  blur_pkg::row_addr_t blur_addr_r,
  output blur_pkg::row_word_t blur_dout,
  input  blur_pkg::row_addr_t blur_addr_w,
  input  logic                blur_we,
  input  blur_pkg::row_word_t blur_din
);

  localparam int IMG_W = NUM_COLS * blur_pkg::STRIP_PIXELS;

  blur_pkg::row_word_t mem [1 << blur_pkg::ADDR_W];

  // one image row of a strip plus the halo, zero outside the image
  function automatic blur_pkg::window_t window_row(int y, int col);
    blur_pkg::window_t win;
    int x;
    win = '0;
    for (int j = 0; j < blur_pkg::WIN_PIXELS; j++) begin
      x = col * blur_pkg::STRIP_PIXELS + j - blur_pkg::HALO;
      if (y < NUM_ROWS && x >= 0 && x < IMG_W) begin
        win[j * blur_pkg::PIXEL_W +: blur_pkg::PIXEL_W] = image[y][x];
      end
    end
    return win;
  endfunction

  initial begin
    buffer_data_0 = '0;
    buffer_data_1 = '0;
    buffer_data_2 = '0;
    blur_dout     = '0;
    // fill varies with the whole row address
    for (int r = 0; r < (1 << blur_pkg::ADDR_W); r++) begin
      mem[r] = {(blur_pkg::ROW_WORD_W / 16){7'h55, blur_pkg::row_addr_t'(r)}};
    end
  end

  // line buffer, row 0 is the newest load
  always @(posedge clk) begin
    if (!rst_n) begin
      buffer_data_0 <= '0;
      buffer_data_1 <= '0;
      buffer_data_2 <= '0;
    end else if (buffer_we) begin
      // first load of a strip starts from an empty buffer
      if (!fill_zero && img_addr == '0) begin
        buffer_data_1 <= '0;
        buffer_data_2 <= '0;
      end else begin
        buffer_data_1 <= buffer_data_0;
        buffer_data_2 <= buffer_data_1;
      end
      buffer_data_0 <= fill_zero ? '0 : window_row(int'(img_addr), int'(current_col));
    end
  end

  // blur memory, one cycle read latency
  always @(posedge clk) begin
    blur_dout <= mem[blur_addr_r];
    if (blur_we) begin
      mem[blur_addr_w] <= blur_din;
    end
  end

endmodule

// ==== verification/tb_gaussian_blur.sv ====
`timescale 1ns/1ps

module tb_gaussian_blur;

  localparam int NUM_COLS    = 3;
  localparam int NUM_ROWS    = 6;
  localparam int IMG_W       = NUM_COLS * blur_pkg::STRIP_PIXELS;
  localparam int CYCLE_LIMIT = 2 * NUM_COLS * (NUM_ROWS + 6) + 100;
  localparam blur_pkg::row_addr_t ROWS     = blur_pkg::row_addr_t'(NUM_ROWS);
  localparam blur_pkg::row_addr_t LOADS    = blur_pkg::row_addr_t'(NUM_ROWS + 2);
  localparam blur_pkg::row_addr_t LAST_ROW = blur_pkg::row_addr_t'(NUM_ROWS - 1);
  localparam blur_pkg::col_idx_t  LAST_COL = blur_pkg::col_idx_t'(NUM_COLS - 1);

  logic                clk;
  logic                rst_n;
  logic                start;
  logic                done;
  blur_pkg::row_addr_t img_addr;
  logic                buffer_we;
  logic                fill_zero;
  blur_pkg::col_idx_t  current_col;
  blur_pkg::window_t   buffer_data_0;
  blur_pkg::window_t   buffer_data_1;
  blur_pkg::window_t   buffer_data_2;
  blur_pkg::row_addr_t blur_addr_r;
  blur_pkg::row_word_t blur_dout;
  blur_pkg::row_addr_t blur_addr_w;
  logic                blur_we;
  blur_pkg::row_word_t blur_din;

  blur_pkg::pixel_t    image [NUM_ROWS][IMG_W];
  blur_pkg::row_word_t first_frame [NUM_ROWS];
  blur_pkg::row_addr_t load_cnt;
  blur_pkg::row_addr_t wr_cnt;
  blur_pkg::col_idx_t  strip_cnt;
  logic                started;
  logic                last_write;
  logic                merge_ok;
  int                  frame_writes = 0;
  int                  done_cnt = 0;
  int                  cycles = 0;
  int                  proto_errs = 0;
  int                  data_errs = 0;

  gaussian_blur_top #(.NUM_COLS(NUM_COLS), .NUM_ROWS(NUM_ROWS)) u_dut (.*);
  tb_blur_env #(.NUM_COLS(NUM_COLS), .NUM_ROWS(NUM_ROWS)) u_env (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int img_at(int y, int x);
    if (y < 0 || y >= NUM_ROWS || x < 0 || x >= IMG_W) begin
      return 0;
    end
    return int'(image[y][x]);
  endfunction

  // 1 2 1 weights in both directions then divide by 16
  function automatic blur_pkg::pixel_t blur_golden(int y, int x);
    int sum;
    sum = 0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        sum += img_at(y + dy, x + dx) * (dy == 0 ? 2 : 1) * (dx == 0 ? 2 : 1);
      end
    end
    return blur_pkg::pixel_t'(sum / 16);
  endfunction

  task automatic protocol_error(string msg);
    proto_errs = proto_errs + 1;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic run_frame();
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do @(posedge clk); while (done !== 1'b1);
  endtask

  task automatic check_memory();
    blur_pkg::pixel_t got;
    blur_pkg::pixel_t want;
    int x;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < blur_pkg::MAX_COLS; c++) begin
        for (int i = 0; i < blur_pkg::STRIP_PIXELS; i++) begin
          x = c * blur_pkg::STRIP_PIXELS + i;
          got = u_env.mem[r][x * blur_pkg::PIXEL_W +: blur_pkg::PIXEL_W];
          want = (c < NUM_COLS) ? blur_golden(r, x) : '0;
          assert (got == want) else begin
            data_errs = data_errs + 1;
            $display("ERR %0t: row %0d strip %0d pixel %0d got %h expected %h",
                     $time, r, c, i, got, want);
          end
        end
      end
    end
  endtask

  // strip ends on its NUM_ROWS-th write
  assign last_write = blur_we && (wr_cnt == LAST_ROW);

  // lower strips match the stored row and upper strips are zero
  always_comb begin
    merge_ok = 1'b1;
    for (int c = 0; c < blur_pkg::MAX_COLS; c++) begin
      if (c < int'(strip_cnt) &&
          blur_din[c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W] !=
          u_env.mem[blur_addr_w][c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W]) begin
        merge_ok = 1'b0;
      end
      if (c > int'(strip_cnt) &&
          blur_din[c * blur_pkg::STRIP_W +: blur_pkg::STRIP_W] != '0) begin
        merge_ok = 1'b0;
      end
    end
  end

  // per strip and per frame bookkeeping
  always @(posedge clk) begin
    if (!rst_n) begin
      started   <= 1'b0;
      load_cnt  <= '0;
      wr_cnt    <= '0;
      strip_cnt <= '0;
    end else begin
      if (start) begin
        started   <= 1'b1;
        strip_cnt <= '0;
      end else if (last_write) begin
        strip_cnt <= strip_cnt + 1'b1;
      end
      if (last_write) begin
        load_cnt <= '0;
        wr_cnt   <= '0;
      end else begin
        if (buffer_we) begin
          load_cnt <= load_cnt + 1'b1;
        end
        if (blur_we) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
      end
      if (start) begin
        frame_writes <= 0;
      end else if (blur_we) begin
        frame_writes <= frame_writes + 1;
      end
      if (done) begin
        done_cnt <= done_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: done was not seen within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $finish;
    end
  end

  a_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !started |-> !done && !buffer_we && !fill_zero && !blur_we &&
                 img_addr == '0 && current_col == '0)
    else protocol_error("outputs not at rest before start");

  a_load: assert property (@(posedge clk) disable iff (!rst_n)
    buffer_we |-> (load_cnt < LOADS) &&
                  ((load_cnt < ROWS) ? (img_addr == load_cnt && !fill_zero) : fill_zero))
    else protocol_error($sformatf("load %0d img_addr %0d fill_zero %b",
                                  load_cnt, img_addr, fill_zero));

  a_fill: assert property (@(posedge clk) disable iff (!rst_n) fill_zero |-> buffer_we)
    else protocol_error("fill_zero without buffer_we");

  a_strip_loads: assert property (@(posedge clk) disable iff (!rst_n)
    last_write |-> load_cnt == LOADS)
    else protocol_error($sformatf("strip ended after %0d loads", load_cnt));

  a_write: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we |-> blur_addr_w == wr_cnt && current_col == strip_cnt &&
                $past(blur_addr_r, 2) == blur_addr_w)
    else protocol_error($sformatf("write to row %0d strip %0d, expected row %0d strip %0d",
                                  blur_addr_w, current_col, wr_cnt, strip_cnt));

  a_merge: assert property (@(posedge clk) disable iff (!rst_n) blur_we |-> merge_ok)
    else protocol_error($sformatf("merged word wrong at row %0d strip %0d",
                                  blur_addr_w, strip_cnt));

  a_done_after: assert property (@(posedge clk) disable iff (!rst_n)
    blur_we && frame_writes == NUM_COLS * NUM_ROWS - 1 |=> done)
    else protocol_error("done missing after the last write");

  a_done_only: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(last_write) && $past(current_col) == LAST_COL &&
             frame_writes == NUM_COLS * NUM_ROWS)
    else protocol_error($sformatf("done after %0d writes", frame_writes));

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else protocol_error("done longer than one cycle");

  initial begin
    logic [31:0] lcg;
    lcg = 32'hf86f1d89;
    for (int y = 0; y < NUM_ROWS; y++) begin
      for (int x = 0; x < IMG_W; x++) begin
        lcg = lcg_next(lcg);
        image[y][x] = lcg[23:16];
      end
    end
    clk   = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    run_frame();
    check_memory();
    for (int r = 0; r < NUM_ROWS; r++) begin
      first_frame[r] = u_env.mem[r];
    end
    repeat (4) @(posedge clk);
    // second frame over the first frame's results
    run_frame();
    @(posedge clk);
    for (int r = 0; r < NUM_ROWS; r++) begin
      assert (u_env.mem[r] == first_frame[r]) else begin
        data_errs = data_errs + 1;
        $display("ERR %0t: row %0d differs on the second frame", $time, r);
      end
    end
    assert (done_cnt == 2) else begin
      data_errs = data_errs + 1;
      $display("ERR %0t: done seen %0d times over two frames", $time, done_cnt);
    end
    $display("errors: %0d protocol, %0d data", proto_errs, data_errs);
    if (proto_errs == 0 && data_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== gaussian_blur.f ====
verilog/blur_pkg.sv
verilog/blur_ctrl_if.sv
verilog/strip_sequencer.sv
verilog/blur_mem_addr_gen.sv
verilog/gauss3_strip.sv
verilog/strip_merge.sv
verilog/gaussian_blur_top.sv
verification/tb_blur_env.sv
verification/tb_gaussian_blur.sv

// ==== Makefile ====
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_gaussian_blur
FILELIST   := gaussian_blur.f
BUILD_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
